/* project.f */
rtl/mini_pkg.sv
rtl/mini_fetch.sv
rtl/mini_regfile.sv
rtl/mini_core.sv
rtl/mini_tracer.sv
rtl/mini_top_tracing.sv
testbench/tb_imem_model.sv
testbench/tb_mini_top.sv

/* rtl/mini_core.sv */
`timescale 1ns/1ns
`default_nettype none

module mini_core (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [31:0]           boot_addr_i,

  // Instruction memory interface
  output logic                  instr_req_o,
  output logic [31:0]           instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [31:0]           instr_rdata_i,
  input  logic                  instr_err_i,

  // Retirement port
  output logic                  retire_valid_o,
  output mini_pkg::retire_rec_t retire_rec_o,
  input  logic                  retire_ready_i,

  output logic                  core_sleep_o
);

  localparam int unsigned XLEN = mini_pkg::XLEN;

  logic            fetch_valid;
  logic [31:0]     fetch_insn;
  logic [XLEN-1:0] fetch_pc;
  logic            fetch_err;
  logic            fetch_take;
  logic [XLEN-1:0] next_pc;

  mini_pkg::instr_t insn;
  logic [XLEN-1:0]  rdata_a;
  logic [XLEN-1:0]  rdata_b;
  logic [XLEN-1:0]  imm_sext;
  logic [XLEN-1:0]  pc_plus4;
  logic [XLEN-1:0]  result;
  logic             rd_we;
  logic             wr_en;
  logic             trap;
  logic             halt;
  logic             retire;

  logic [31:0]      order_q;
  logic             sleep_q;

  mini_fetch u_fetch (
    .clk_i,
    .rst_i,
    .boot_addr_i,
    .instr_req_o,
    .instr_addr_o,
    .instr_gnt_i,
    .instr_rvalid_i,
    .instr_rdata_i,
    .instr_err_i,
    .fetch_valid_o (fetch_valid),
    .fetch_insn_o  (fetch_insn),
    .fetch_pc_o    (fetch_pc),
    .fetch_err_o   (fetch_err),
    .fetch_take_i  (fetch_take),
    .next_pc_i     (next_pc),
    .halt_i        (halt)
  );

  assign insn     = mini_pkg::instr_t'(fetch_insn);
  assign imm_sext = {{(XLEN - 16){insn.imm[15]}}, insn.imm};
  assign pc_plus4 = fetch_pc + XLEN'(4);

  mini_regfile u_regfile (
    .clk_i,
    .rst_i,
    .raddr_a_i (insn.rs1),
    .raddr_b_i (insn.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (retire && wr_en),
    .waddr_i   (insn.rd),
    .wdata_i   (result)
  );

  // Decode and execute
  always_comb begin
    rd_we   = 1'b0;
    result  = '0;
    next_pc = pc_plus4;
    trap    = 1'b0;
    halt    = 1'b0;
    case (insn.opcode)
      mini_pkg::OP_ADD: begin
        rd_we  = 1'b1;
        result = rdata_a + rdata_b;
      end
      mini_pkg::OP_SUB: begin
        rd_we  = 1'b1;
        result = rdata_a - rdata_b;
      end
      mini_pkg::OP_AND: begin
        rd_we  = 1'b1;
        result = rdata_a & rdata_b;
      end
      mini_pkg::OP_XOR: begin
        rd_we  = 1'b1;
        result = rdata_a ^ rdata_b;
      end
      mini_pkg::OP_ADDI: begin
        rd_we  = 1'b1;
        result = rdata_a + imm_sext;
      end
      mini_pkg::OP_BEQ: begin
        // Offset counts words
        if (rdata_a == rdata_b) begin
          next_pc = fetch_pc + {imm_sext[XLEN-3:0], 2'b00};
        end
      end
      mini_pkg::OP_HALT: begin
        halt    = 1'b1;
        next_pc = fetch_pc;
      end
      default: trap = 1'b1;
    endcase
    // A bus error overrides whatever the word decoded to
    if (fetch_err) begin
      rd_we   = 1'b0;
      halt    = 1'b0;
      trap    = 1'b1;
      next_pc = pc_plus4;
    end
  end

  assign wr_en      = rd_we && (insn.rd != 3'd0);
  assign retire     = fetch_valid && retire_ready_i;
  assign fetch_take = retire;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      order_q <= '0;
      sleep_q <= 1'b0;
    end else if (retire) begin
      order_q <= order_q + 32'd1;
      if (halt) sleep_q <= 1'b1;
    end
  end

  assign retire_valid_o = fetch_valid;

  always_comb begin
    retire_rec_o.order    = order_q;
    retire_rec_o.insn     = fetch_insn;
    retire_rec_o.pc_rdata = fetch_pc;
    retire_rec_o.pc_wdata = next_pc;
    retire_rec_o.rd_addr  = wr_en ? insn.rd : 3'd0;
    retire_rec_o.rd_wdata = wr_en ? result : '0;
    retire_rec_o.trap     = trap;
    retire_rec_o.halt     = halt;
  end

  assign core_sleep_o = sleep_q;

  // Fetch must stay quiet once the core sleeps
  no_retire_asleep: assert property (@(posedge clk_i) disable iff (rst_i)
    core_sleep_o |-> !retire_valid_o && !instr_req_o);

endmodule

`default_nettype wire

/* rtl/mini_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module mini_fetch (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [31:0]               boot_addr_i,

  // Instruction memory side
  output logic                      instr_req_o,
  output logic [31:0]               instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [31:0]               instr_rdata_i,
  input  logic                      instr_err_i,

  // Core side
  output logic                      fetch_valid_o,
  output logic [31:0]               fetch_insn_o,
  output logic [mini_pkg::XLEN-1:0] fetch_pc_o,
  output logic                      fetch_err_o,
  input  logic                      fetch_take_i,
  input  logic [mini_pkg::XLEN-1:0] next_pc_i,
  input  logic                      halt_i
);

  typedef enum logic [1:0] {
    FE_IDLE,
    FE_REQ,
    FE_WAIT,
    FE_HOLD
  } fe_state_e;

  fe_state_e                 state_q;
  logic [mini_pkg::XLEN-1:0] pc_q;
  logic                      halted_q;
  logic [31:0]               insn_q;
  logic                      err_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= FE_IDLE;
      pc_q     <= boot_addr_i;
      halted_q <= 1'b0;
    end else begin
      case (state_q)
        // Idle only between reset and the first request, or after a halt
        FE_IDLE: if (!halted_q) state_q <= FE_REQ;
        FE_REQ:  if (instr_gnt_i) state_q <= FE_WAIT;
        FE_WAIT: if (instr_rvalid_i) state_q <= FE_HOLD;
        FE_HOLD: begin
          if (fetch_take_i) begin
            if (halt_i) begin
              halted_q <= 1'b1;
              state_q  <= FE_IDLE;
            end else begin
              pc_q    <= next_pc_i;
              state_q <= FE_REQ;
            end
          end
        end
        default: state_q <= FE_IDLE;
      endcase
    end
  end

  // Response capture
  always_ff @(posedge clk_i) begin
    if (state_q == FE_WAIT && instr_rvalid_i) begin
      insn_q <= instr_rdata_i;
      err_q  <= instr_err_i;
    end
  end

  assign instr_req_o   = (state_q == FE_REQ);
  assign instr_addr_o  = pc_q;
  assign fetch_valid_o = (state_q == FE_HOLD);
  assign fetch_insn_o  = insn_q;
  assign fetch_pc_o    = pc_q;
  assign fetch_err_o   = err_q;

  // Request address must not move before the grant
  req_addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

`default_nettype wire

/* rtl/mini_pkg.sv */
`default_nettype none

package mini_pkg;

  // Datapath width
  localparam int unsigned XLEN = 32;

  // Width of the tracer cycle counter
  localparam int unsigned CycleW = 32;

  // Seven legal opcodes, every other code traps
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_XOR  = 4'h3,
    OP_ADDI = 4'h4,
    OP_BEQ  = 4'h5,
    OP_HALT = 4'hF
  } opcode_e;

  // Instruction word, opcode in the top nibble
  typedef struct packed {
    opcode_e     opcode;
    logic [2:0]  rd;
    logic [2:0]  rs1;
    logic [2:0]  rs2;
    logic [2:0]  rsvd;
    logic [15:0] imm;
  } instr_t;

  // One record per retired instruction
  typedef struct packed {
    logic [31:0]     order;
    logic [31:0]     insn;
    logic [XLEN-1:0] pc_rdata;
    logic [XLEN-1:0] pc_wdata;
    // Both zero when no register is written
    logic [2:0]      rd_addr;
    logic [XLEN-1:0] rd_wdata;
    logic            trap;
    logic            halt;
  } retire_rec_t;

  // Retirement record stamped by the tracer
  typedef struct packed {
    logic [CycleW-1:0] cycle;
    retire_rec_t       rec;
  } trace_rec_t;

endpackage

`default_nettype wire

/* rtl/mini_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module mini_regfile (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [2:0]                raddr_a_i,
  input  logic [2:0]                raddr_b_i,
  output logic [mini_pkg::XLEN-1:0] rdata_a_o,
  output logic [mini_pkg::XLEN-1:0] rdata_b_o,
  input  logic                      we_i,
  input  logic [2:0]                waddr_i,
  input  logic [mini_pkg::XLEN-1:0] wdata_i
);

  // Entry 0 exists but is never written
  logic [mini_pkg::XLEN-1:0] regs_q [8];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 8; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != 3'd0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == 3'd0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 3'd0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* rtl/mini_top_tracing.sv */
`timescale 1ns/1ns
`default_nettype none

module mini_top_tracing #(
  parameter int unsigned TraceDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [31:0]          boot_addr_i,

  // Instruction memory interface
  output logic                 instr_req_o,
  output logic [31:0]          instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  logic [31:0]          instr_rdata_i,
  input  logic                 instr_err_i,

  // Trace stream
  output logic                 trace_valid_o,
  output mini_pkg::trace_rec_t trace_rec_o,
  input  logic                 trace_ready_i,

  output logic                 core_sleep_o
);

  logic                  retire_valid;
  logic                  retire_ready;
  mini_pkg::retire_rec_t retire_rec;

  mini_core u_mini_core (
    .clk_i,
    .rst_i,
    .boot_addr_i,
    .instr_req_o,
    .instr_addr_o,
    .instr_gnt_i,
    .instr_rvalid_i,
    .instr_rdata_i,
    .instr_err_i,
    .retire_valid_o (retire_valid),
    .retire_rec_o   (retire_rec),
    .retire_ready_i (retire_ready),
    .core_sleep_o
  );

  mini_tracer #(
    .TraceDepth (TraceDepth)
  ) u_mini_tracer (
    .clk_i,
    .rst_i,
    .retire_valid_i (retire_valid),
    .retire_rec_i   (retire_rec),
    .retire_ready_o (retire_ready),
    .trace_valid_o,
    .trace_rec_o,
    .trace_ready_i
  );

endmodule

`default_nettype wire

/* rtl/mini_tracer.sv */
`timescale 1ns/1ns
`default_nettype none

module mini_tracer #(
  parameter int unsigned TraceDepth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,

  input  logic                  retire_valid_i,
  input  mini_pkg::retire_rec_t retire_rec_i,
  output logic                  retire_ready_o,

  output logic                  trace_valid_o,
  output mini_pkg::trace_rec_t  trace_rec_o,
  input  logic                  trace_ready_i
);

  localparam int unsigned PtrW = $clog2(TraceDepth);

  logic [mini_pkg::CycleW-1:0] cycle_q;

  mini_pkg::trace_rec_t fifo_q [TraceDepth];

  // Extra top bit tells full from empty
  logic [PtrW:0] wr_ptr_q;
  logic [PtrW:0] rd_ptr_q;
  logic [PtrW:0] level;
  logic          full;
  logic          empty;
  logic          push;
  logic          pop;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[PtrW] != rd_ptr_q[PtrW]) &&
                 (wr_ptr_q[PtrW-1:0] == rd_ptr_q[PtrW-1:0]);
  assign level = wr_ptr_q - rd_ptr_q;

  assign pop            = trace_valid_o && trace_ready_i;
  assign retire_ready_o = !full || pop;
  assign push           = retire_valid_i && retire_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // Stamp with the cycle of acceptance
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q[PtrW-1:0]].cycle <= cycle_q;
      fifo_q[wr_ptr_q[PtrW-1:0]].rec   <= retire_rec_i;
    end
  end

  assign trace_valid_o = !empty;
  assign trace_rec_o   = fifo_q[rd_ptr_q[PtrW-1:0]];

  // Occupancy never grows past the depth
  fifo_level_ok: assert property (@(posedge clk_i) disable iff (rst_i)
    level <= TraceDepth);

  // Core keeps a refused record unchanged
  held_rec_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    retire_valid_i && !retire_ready_o |=> retire_valid_i && $stable(retire_rec_i));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator, once per trace FIFO depth
cd "$(dirname "$0")" || exit 1

status=0
for depth in 4 2; do
  build_dir="build/depth_$depth"
  log="$build_dir/sim.log"
  mkdir -p "$build_dir" || exit 1

  verilator --binary --timing --assert --top-module tb_mini_top \
    -GTraceDepth=$depth -f project.f -Mdir "$build_dir" -o sim
  if [ $? -ne 0 ]; then
    echo "compile failed for TraceDepth=$depth"
    exit 1
  fi

  "$build_dir/sim" > "$log" 2>&1
  sim_status=$?
  cat "$log"
  if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status for TraceDepth=$depth"
    status=1
  fi

  if grep -q "^TEST OK$" "$log"; then
    echo "TraceDepth=$depth: passed"
  else
    echo "TraceDepth=$depth: failed"
    status=1
  fi
done

exit $status

/* testbench/tb_imem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_imem_model (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] boot_addr_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  // Word storage, word 0 sits at the boot address
  logic [31:0] mem [256];
  logic        err_mem [256];

  int          gnt_wait;
  int          rsp_wait;
  logic [7:0]  rsp_idx;
  logic        in_reset;

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    gnt_wait = -1;
    rsp_wait = -1;
    rsp_idx  = '0;
    forever begin
      @(posedge clk_i);
      in_reset = rst_i;
      #1;
      gnt_o    = 1'b0;
      rvalid_o = 1'b0;
      if (in_reset) begin
        gnt_wait = -1;
        rsp_wait = -1;
      end else if (rsp_wait == 0) begin
        rvalid_o = 1'b1;
        rdata_o  = mem[rsp_idx];
        err_o    = err_mem[rsp_idx];
        rsp_wait = -1;
      end else if (rsp_wait > 0) begin
        rsp_wait--;
      end else if (req_i) begin
        // Grant after 0 to 3 cycles, response 1 to 4 cycles after the grant
        if (gnt_wait < 0) gnt_wait = int'($urandom % 4);
        if (gnt_wait == 0) begin
          gnt_o    = 1'b1;
          rsp_idx  = 8'((addr_i - boot_addr_i) >> 2);
          rsp_wait = int'($urandom % 4);
          gnt_wait = -1;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_mini_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mini_top #(
  parameter int unsigned TraceDepth = 4
);

  // Run bounds of 40 instructions per test and 60 cycles each with stalls
  localparam int NumTests      = 6;
  localparam int MaxInsns      = 40;
  localparam int CyclesPerInsn = 60;
  localparam int ProgCycles    = MaxInsns * CyclesPerInsn;
  localparam int TimeoutCycles = NumTests * ProgCycles;

  logic                 clk_i = 1'b0;
  logic                 rst_i = 1'b1;
  logic [31:0]          boot_addr_i = '0;
  logic                 instr_req_o;
  logic [31:0]          instr_addr_o;
  logic                 instr_gnt_i;
  logic                 instr_rvalid_i;
  logic [31:0]          instr_rdata_i;
  logic                 instr_err_i;
  logic                 trace_valid_o;
  mini_pkg::trace_rec_t trace_rec_o;
  logic                 trace_ready_i = 1'b0;
  logic                 core_sleep_o;

  // Program image and reference state
  logic [31:0]           prog [256];
  logic                  prog_err [256];
  int                    prog_len;
  logic [31:0]           m_regs [8];
  logic [31:0]           m_pc;
  logic [31:0]           m_order;
  mini_pkg::retire_rec_t last_rec;

  int test_num = 0;
  int tests_failed = 0;
  int checks = 0;
  int errors = 0;
  int test_errors = 0;
  int cycle_count = 0;
  int fetched = 0;
  int popped = 0;

  always #5 clk_i = ~clk_i;

  mini_top_tracing #(
    .TraceDepth (TraceDepth)
  ) DUT (
    .clk_i,
    .rst_i,
    .boot_addr_i,
    .instr_req_o,
    .instr_addr_o,
    .instr_gnt_i,
    .instr_rvalid_i,
    .instr_rdata_i,
    .instr_err_i,
    .trace_valid_o,
    .trace_rec_o,
    .trace_ready_i,
    .core_sleep_o
  );

  tb_imem_model imem (
    .clk_i,
    .rst_i,
    .boot_addr_i,
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i),
    .err_o    (instr_err_i)
  );

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count == TimeoutCycles) begin
      $display("timeout: run passed %0d cycles without finishing", TimeoutCycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic note_mismatch(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("mismatch %s: got %h, expected %h", sig, got, exp);
    errors++;
    test_errors++;
  endtask

  task automatic note_failure(input string msg);
    $display("error: %s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic check_rec(input mini_pkg::retire_rec_t got, input mini_pkg::retire_rec_t exp);
    checks++;
    if (got.order != exp.order) note_mismatch("rec.order", got.order, exp.order);
    if (got.insn != exp.insn) note_mismatch("rec.insn", got.insn, exp.insn);
    if (got.pc_rdata != exp.pc_rdata)
      note_mismatch("rec.pc_rdata", got.pc_rdata, exp.pc_rdata);
    if (got.pc_wdata != exp.pc_wdata)
      note_mismatch("rec.pc_wdata", got.pc_wdata, exp.pc_wdata);
    if (got.rd_addr != exp.rd_addr)
      note_mismatch("rec.rd_addr", 32'(got.rd_addr), 32'(exp.rd_addr));
    if (got.rd_wdata != exp.rd_wdata)
      note_mismatch("rec.rd_wdata", got.rd_wdata, exp.rd_wdata);
    if (got.trap != exp.trap) note_mismatch("rec.trap", 32'(got.trap), 32'(exp.trap));
    if (got.halt != exp.halt) note_mismatch("rec.halt", 32'(got.halt), 32'(exp.halt));
  endtask

  task automatic check_bit(input string sig, input logic got, input logic exp);
    checks++;
    if (got != exp) note_mismatch(sig, 32'(got), 32'(exp));
  endtask

  task automatic check_cycle(input logic [31:0] got, input logic [31:0] prev);
    checks++;
    if (got <= prev) begin
      $display("mismatch trace_rec_o.cycle: got %h, expected above %h", got, prev);
      errors++;
      test_errors++;
    end
  endtask

  task automatic begin_test();
    test_num++;
    test_errors = 0;
  endtask

  task automatic end_test(input string name);
    if (test_errors != 0) tests_failed++;
    $display("test %0d %s: %s, %0d errors", test_num, name,
             (test_errors == 0) ? "pass" : "fail", test_errors);
  endtask

  function automatic logic [31:0] encode(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs1, input logic [2:0] rs2,
                                         input logic [15:0] imm);
    mini_pkg::instr_t in;
    in.opcode = mini_pkg::opcode_e'(op);
    in.rd     = rd;
    in.rs1    = rs1;
    in.rs2    = rs2;
    in.rsvd   = 3'b000;
    in.imm    = imm;
    return in;
  endfunction

  // Unused words hold an illegal opcode tagged with their address
  task automatic new_program(input logic [31:0] boot);
    logic [31:0] addr;
    boot_addr_i = boot;
    prog_len = 0;
    for (int i = 0; i < 256; i++) begin
      addr = boot + 32'(i) * 32'd4;
      prog[i] = {4'hE, addr[27:0] ^ {addr[31:28], 24'h0}};
      prog_err[i] = 1'b0;
    end
  endtask

  task automatic emit(input logic [31:0] word, input logic err);
    prog[prog_len] = word;
    prog_err[prog_len] = err;
    prog_len++;
  endtask

  task automatic start_program();
    for (int i = 0; i < 256; i++) begin
      imem.mem[i] = prog[i];
      imem.err_mem[i] = prog_err[i];
    end
    for (int i = 0; i < 8; i++) begin
      m_regs[i] = '0;
    end
    m_pc = boot_addr_i;
    m_order = '0;
    fetched = 0;
    popped = 0;
    rst_i = 1'b1;
    repeat (3) begin
      @(posedge clk_i);
      #1;
      check_bit("instr_req_o", instr_req_o, 1'b0);
      check_bit("trace_valid_o", trace_valid_o, 1'b0);
    end
    rst_i = 1'b0;
  endtask

  // Reference model of one retirement
  task automatic predict_next(output mini_pkg::retire_rec_t exp);
    logic [7:0]       idx;
    mini_pkg::instr_t in;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      imm;
    logic [31:0]      res;
    logic             wr;
    idx = 8'((m_pc - boot_addr_i) >> 2);
    in = mini_pkg::instr_t'(prog[idx]);
    a = m_regs[in.rs1];
    b = m_regs[in.rs2];
    imm = {{16{in.imm[15]}}, in.imm};
    res = '0;
    wr = 1'b0;
    exp = '0;
    exp.order = m_order;
    exp.insn = prog[idx];
    exp.pc_rdata = m_pc;
    exp.pc_wdata = m_pc + 32'd4;
    case (in.opcode)
      mini_pkg::OP_ADD: begin
        res = a + b;
        wr = 1'b1;
      end
      mini_pkg::OP_SUB: begin
        res = a - b;
        wr = 1'b1;
      end
      mini_pkg::OP_AND: begin
        res = a & b;
        wr = 1'b1;
      end
      mini_pkg::OP_XOR: begin
        res = a ^ b;
        wr = 1'b1;
      end
      mini_pkg::OP_ADDI: begin
        res = a + imm;
        wr = 1'b1;
      end
      mini_pkg::OP_BEQ: if (a == b) exp.pc_wdata = m_pc + (imm << 2);
      mini_pkg::OP_HALT: begin
        exp.halt = 1'b1;
        exp.pc_wdata = m_pc;
      end
      default: exp.trap = 1'b1;
    endcase
    if (prog_err[idx]) begin
      exp.trap = 1'b1;
      exp.halt = 1'b0;
      exp.pc_wdata = m_pc + 32'd4;
      wr = 1'b0;
    end
    if (wr && in.rd != 3'd0) begin
      exp.rd_addr = in.rd;
      exp.rd_wdata = res;
      m_regs[in.rd] = res;
    end
    m_pc = exp.pc_wdata;
    m_order = m_order + 32'd1;
  endtask

  // Consume trace records up to the halt record with ready low in the stall window
  task automatic run_program(input int stall_start, input int stall_len);
    mini_pkg::trace_rec_t  got;
    mini_pkg::trace_rec_t  held;
    mini_pkg::retire_rec_t exp;
    logic [31:0]           prev_cycle;
    logic                  held_valid;
    logic                  done;
    int                    t;
    prev_cycle = '0;
    held = '0;
    held_valid = 1'b0;
    done = 1'b0;
    t = 0;
    trace_ready_i = !(t >= stall_start && t < stall_start + stall_len);
    while (!done && t < ProgCycles) begin
      @(negedge clk_i);
      if (instr_rvalid_i) fetched++;
      // At most one record waits in the core beyond a full FIFO
      if (instr_req_o && fetched - popped > int'(TraceDepth))
        note_failure("instruction request issued while the trace FIFO was full");
      if (held_valid && (!trace_valid_o || trace_rec_o != held))
        note_failure("trace record changed while the consumer stalled");
      held_valid = trace_valid_o && !trace_ready_i;
      held = trace_rec_o;
      if (trace_valid_o && trace_ready_i) begin
        got = trace_rec_o;
        predict_next(exp);
        check_rec(got.rec, exp);
        if (popped > 0) check_cycle(got.cycle, prev_cycle);
        prev_cycle = got.cycle;
        popped++;
        last_rec = got.rec;
        done = got.rec.halt;
      end
      @(posedge clk_i);
      #1;
      t++;
      trace_ready_i = !(t >= stall_start && t < stall_start + stall_len);
    end
    if (!done) note_failure("program did not retire its halt instruction in time");
  endtask

  task automatic test_reset();
    int t;
    begin_test();
    new_program(32'h0000_0100);
    emit(encode(mini_pkg::OP_ADDI, 3'd1, 3'd0, 3'd0, 16'd5), 1'b0);
    emit(encode(mini_pkg::OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0), 1'b0);
    trace_ready_i = 1'b0;
    start_program();
    check_bit("trace_valid_o", trace_valid_o, 1'b0);
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    t = 0;
    do begin
      @(negedge clk_i);
      t++;
    end while (!instr_req_o && t < CyclesPerInsn);
    if (!instr_req_o) note_failure("no instruction request after reset");
    checks++;
    if (instr_addr_o != boot_addr_i) note_mismatch("instr_addr_o", instr_addr_o, boot_addr_i);
    while (!instr_rvalid_i && t < CyclesPerInsn) begin
      @(negedge clk_i);
      t++;
    end
    if (!instr_rvalid_i) note_failure("no instruction response after the first request");
    fetched = 1;
    // Registered fetch, then retire, then the FIFO output
    @(negedge clk_i);
    check_bit("trace_valid_o", trace_valid_o, 1'b0);
    @(negedge clk_i);
    check_bit("trace_valid_o", trace_valid_o, 1'b1);
    @(posedge clk_i);
    #1;
    run_program(0, 0);
    end_test("reset and first record");
  endtask

  task automatic test_alu();
    begin_test();
    new_program(32'h0000_2000);
    emit(encode(mini_pkg::OP_ADDI, 3'd1, 3'd0, 3'd0, 16'd100), 1'b0);
    emit(encode(mini_pkg::OP_ADDI, 3'd2, 3'd0, 3'd0, -16'sd7), 1'b0);
    emit(encode(mini_pkg::OP_ADD, 3'd3, 3'd1, 3'd2, 16'd0), 1'b0);
    emit(encode(mini_pkg::OP_SUB, 3'd4, 3'd2, 3'd1, 16'd0), 1'b0);
    emit(encode(mini_pkg::OP_AND, 3'd5, 3'd3, 3'd4, 16'd0), 1'b0);
    emit(encode(mini_pkg::OP_XOR, 3'd6, 3'd4, 3'd1, 16'd0), 1'b0);
    // Writes to register 0 are dropped
    emit(encode(mini_pkg::OP_ADDI, 3'd0, 3'd1, 3'd0, 16'd55), 1'b0);
    emit(encode(mini_pkg::OP_ADD, 3'd0, 3'd1, 3'd1, 16'd0), 1'b0);
    emit(encode(mini_pkg::OP_ADD, 3'd7, 3'd0, 3'd1, 16'd0), 1'b0);
    emit(encode(mini_pkg::OP_ADDI, 3'd7, 3'd7, 3'd0, 16'h8000), 1'b0);
    emit(encode(mini_pkg::OP_SUB, 3'd1, 3'd1, 3'd1, 16'd0), 1'b0);
    emit(encode(mini_pkg::OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0), 1'b0);
    start_program();
    run_program(0, 0);
    end_test("alu");
  endtask

  task automatic test_branch();
    begin_test();
    new_program(32'h0000_0400);
    emit(encode(mini_pkg::OP_ADDI, 3'd1, 3'd0, 3'd0, 16'd3), 1'b0);
    // Countdown loop with a forward exit and a backward jump
    emit(encode(mini_pkg::OP_ADDI, 3'd1, 3'd1, 3'd0, -16'sd1), 1'b0);
    emit(encode(mini_pkg::OP_BEQ, 3'd0, 3'd1, 3'd0, 16'd2), 1'b0);
    emit(encode(mini_pkg::OP_BEQ, 3'd0, 3'd0, 3'd0, -16'sd2), 1'b0);
    emit(encode(mini_pkg::OP_ADDI, 3'd3, 3'd0, 3'd0, 16'd9), 1'b0);
    emit(encode(mini_pkg::OP_BEQ, 3'd0, 3'd3, 3'd0, 16'd5), 1'b0);
    emit(encode(mini_pkg::OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0), 1'b0);
    start_program();
    run_program(0, 0);
    end_test("branches");
  endtask

  task automatic test_trap();
    begin_test();
    new_program(32'h0000_0800);
    emit(encode(mini_pkg::OP_ADDI, 3'd1, 3'd0, 3'd0, 16'd11), 1'b0);
    emit(encode(4'h9, 3'd2, 3'd1, 3'd1, 16'd0), 1'b0);
    emit(encode(mini_pkg::OP_ADDI, 3'd2, 3'd0, 3'd0, 16'd22), 1'b1);
    emit(encode(mini_pkg::OP_ADD, 3'd3, 3'd1, 3'd1, 16'd0), 1'b0);
    emit(encode(4'hC, 3'd4, 3'd3, 3'd0, 16'd1), 1'b0);
    // Registers named by trapped instructions still read zero
    emit(encode(mini_pkg::OP_ADD, 3'd5, 3'd2, 3'd4, 16'd0), 1'b0);
    emit(encode(mini_pkg::OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0), 1'b0);
    start_program();
    run_program(0, 0);
    end_test("traps");
  endtask

  task automatic test_backpressure();
    begin_test();
    new_program(32'h0000_1000);
    for (int i = 0; i < 18; i++) begin
      emit(encode(mini_pkg::OP_ADDI, 3'((i % 7) + 1), 3'((i + 3) % 8), 3'd0,
                  16'(i * 3 - 20)), 1'b0);
    end
    emit(encode(mini_pkg::OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0), 1'b0);
    start_program();
    run_program(2, 30);
    checks++;
    if (popped != prog_len) note_mismatch("record count", 32'(popped), 32'(prog_len));
    end_test("back-pressure");
  endtask

  task automatic test_halt();
    logic quiet;
    begin_test();
    new_program(32'h0000_0040);
    emit(encode(mini_pkg::OP_ADDI, 3'd1, 3'd0, 3'd0, 16'd1), 1'b0);
    emit(encode(mini_pkg::OP_ADDI, 3'd2, 3'd1, 3'd0, 16'd1), 1'b0);
    emit(encode(mini_pkg::OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0), 1'b0);
    emit(encode(mini_pkg::OP_ADDI, 3'd3, 3'd0, 3'd0, 16'd3), 1'b0);
    start_program();
    run_program(0, 0);
    check_bit("rec.halt", last_rec.halt, 1'b1);
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
    quiet = 1'b1;
    repeat (50) begin
      @(negedge clk_i);
      if (instr_req_o || trace_valid_o) quiet = 1'b0;
    end
    if (!quiet) note_failure("request or record seen after the core went to sleep");
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
    end_test("halt");
  endtask

  initial begin
    void'($urandom(32'h541));
    @(posedge clk_i);
    #1;
    test_reset();
    test_alu();
    test_branch();
    test_trap();
    test_backpressure();
    test_halt();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_num, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
